/* hw/irq_pkg.sv */
`default_nettype none

package irq_pkg;

    localparam int NUM_IRQ = 4;

    typedef logic [11:0]        pc_t;       // fetch byte address
    typedef logic [1:0]         cause_t;    // index of the granted source
    typedef logic [NUM_IRQ-1:0] irq_vec_t;
    typedef logic [31:0]        instr_t;

    // vector table starts here with one 16 byte slot per source
    localparam pc_t ISR_BASE         = 12'h100;
    localparam int  ISR_STRIDE_SHIFT = 4;

    // fetch-enabled cycles the pipeline needs to empty before a redirect
    localparam int DRAIN_CYCLES = 3;
    localparam int DRAIN_CNT_W  = $clog2(DRAIN_CYCLES + 1);

    // whole uret word, the opcode alone would also match ecall and csr ops
    localparam instr_t URET_INSTR = 32'h00200073;

    typedef enum logic [1:0] {
        IDLE,       // waiting for a request
        DRAIN,      // emptying the pipeline before the vector jump
        RUN,        // service routine is executing
        RET_DRAIN   // emptying the pipeline before the return jump
    } ctrl_state_t;

endpackage

`default_nettype wire

/* hw/irq_ctrl_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface irq_ctrl_if;
    import irq_pkg::*;

    logic   enter;  // one-cycle pulse, jump to the vector of cause
    logic   ret;    // one-cycle pulse, jump back to the saved pc
    logic   stall;  // hold the fetch pc while the pipeline drains
    cause_t cause;

    modport ctrl (
        output enter,
        output ret,
        output stall,
        output cause
    );

    modport seq (
        input enter,
        input ret,
        input stall,
        input cause
    );

endinterface

`default_nettype wire

/* hw/irq_pending.sv */
`timescale 1ns/10ps
`default_nettype none

module irq_pending (
    input  logic              clk,
    input  logic              nrst,
    input  irq_pkg::irq_vec_t irq_n,
    input  irq_pkg::irq_vec_t irq_mask,
    input  logic              ack,
    output logic              req,
    output irq_pkg::cause_t   req_cause
);
    import irq_pkg::*;

    irq_vec_t sync_a;
    irq_vec_t sync_b;
    irq_vec_t sync_d;   // last synchronized level, the edge register
    irq_vec_t fall;
    irq_vec_t clr;
    irq_vec_t pending;

    // lines are active low so a request is a high to low transition
    assign fall = sync_d & ~sync_b;

    // ack retires whichever source is currently granted
    assign clr = ack ? (irq_vec_t'(1) << req_cause) : '0;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            sync_a  <= '1;  // idle level of the lines
            sync_b  <= '1;
            sync_d  <= '1;
            pending <= '0;
        end else begin
            sync_a  <= irq_n;
            sync_b  <= sync_a;
            sync_d  <= sync_b;
            // a fresh edge on a just acknowledged line is kept
            pending <= (pending & ~clr) | (fall & irq_mask);
        end
    end

    // fixed priority, the scan ends on the lowest set index
    always_comb begin
        req_cause = '0;
        for (int i = NUM_IRQ - 1; i >= 0; i--) begin
            if (pending[i]) begin
                req_cause = cause_t'(i);
            end
        end
    end

    assign req = |pending;

    // the controller may only accept what is actually pending
    a_ack_needs_req : assert property (@(posedge clk) disable iff (!nrst) ack |-> req)
        else $error("ack raised with no pending request");

endmodule

`default_nettype wire

/* hw/pc_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module pc_sequencer (
    input  logic         clk,
    input  logic         nrst,
    irq_ctrl_if.seq      ctrl,
    input  irq_pkg::pc_t save_pc,
    input  logic         fetch_en,
    input  logic         branch_taken,
    input  irq_pkg::pc_t branch_target,
    output irq_pkg::pc_t pc
);
    import irq_pkg::*;

    pc_t vector;
    pc_t pc_inc;

    assign vector = ISR_BASE + (pc_t'(ctrl.cause) << ISR_STRIDE_SHIFT);
    assign pc_inc = pc + pc_t'(4);

    // earlier branches of the chain win, every load lands on the next edge
    always_ff @(posedge clk) begin
        if (!nrst) begin
            pc <= '0;
        end else if (ctrl.enter) begin
            pc <= vector;
        end else if (ctrl.ret) begin
            pc <= save_pc;
        end else if (ctrl.stall) begin
            pc <= pc;                   // pipeline is draining
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (fetch_en) begin
            pc <= pc_inc;
        end
    end

    // entry and return are separate phases of the controller
    a_enter_ret_excl : assert property (@(posedge clk) disable iff (!nrst)
        !(ctrl.enter && ctrl.ret))
        else $error("enter and ret raised in the same cycle");

endmodule

`default_nettype wire

/* hw/interrupt_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module interrupt_controller (
    input  logic            clk,
    input  logic            nrst,
    input  logic            req,
    input  irq_pkg::cause_t req_cause,
    output logic            ack,
    input  irq_pkg::pc_t    pc,
    input  irq_pkg::instr_t instr,
    input  logic            fetch_en,
    input  logic            branch_taken,
    input  irq_pkg::pc_t    branch_target,
    irq_ctrl_if.ctrl        ctrl,
    output irq_pkg::pc_t    save_pc,
    output logic            isr_active
);
    import irq_pkg::*;

    typedef logic [DRAIN_CNT_W-1:0] drain_cnt_t;

    ctrl_state_t state;
    drain_cnt_t  drain_cnt;     // fetch-enabled cycles seen in this drain
    cause_t      cause_q;
    logic        stall_q;
    logic        draining;
    logic        drain_last;
    logic        uret_seen;

    assign draining = (state == DRAIN) || (state == RET_DRAIN);

    // the final enabled drain cycle also carries the redirect pulse
    assign drain_last = draining && fetch_en &&
                        (drain_cnt == drain_cnt_t'(DRAIN_CYCLES - 1));

    assign uret_seen = (state == RUN) && fetch_en && (instr == URET_INSTR);

    // requests are only taken when idle, so nothing nests
    assign ack = (state == IDLE) && req;

    assign ctrl.enter = drain_last && (state == DRAIN);
    assign ctrl.ret   = drain_last && (state == RET_DRAIN);
    assign ctrl.stall = stall_q;
    assign ctrl.cause = cause_q;

    assign isr_active = (state == RUN) || (state == RET_DRAIN);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state     <= IDLE;
            drain_cnt <= '0;
            stall_q   <= 1'b0;
            cause_q   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state   <= DRAIN;
                        stall_q <= 1'b1;
                        cause_q <= req_cause;
                    end
                end
                DRAIN, RET_DRAIN: begin
                    // a cycle without fetch_en does not move the pipeline
                    if (drain_last) begin
                        drain_cnt <= '0;
                        stall_q   <= 1'b0;
                        if (state == DRAIN) begin
                            state <= RUN;
                        end else begin
                            state <= IDLE;
                        end
                    end else if (fetch_en) begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                RUN: begin
                    if (uret_seen) begin
                        state   <= RET_DRAIN;
                        stall_q <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // a branch resolving behind the interrupt point moves the return address
    always_ff @(posedge clk) begin
        if (!nrst) begin
            save_pc <= '0;
        end else if (ack) begin
            save_pc <= pc;
        end else if ((state == DRAIN) && branch_taken) begin
            save_pc <= branch_target;
        end
    end

    a_stall_in_drain : assert property (@(posedge clk) disable iff (!nrst)
        ctrl.stall == draining)
        else $error("stall level out of step with the drain states");

    a_ret_to_idle : assert property (@(posedge clk) disable iff (!nrst)
        ctrl.ret |=> (state == IDLE))
        else $error("controller not idle after ret");

endmodule

`default_nettype wire

/* hw/irq_top.sv */
`timescale 1ns/10ps
`default_nettype none

module irq_top (
    input  logic              clk,
    input  logic              nrst,
    input  irq_pkg::irq_vec_t irq_n,
    input  irq_pkg::irq_vec_t irq_mask,
    input  irq_pkg::instr_t   instr,
    input  logic              fetch_en,
    input  logic              branch_taken,
    input  irq_pkg::pc_t      branch_target,
    output irq_pkg::pc_t      pc,
    output irq_pkg::pc_t      save_pc,
    output logic              isr_stall,
    output logic              isr_active,
    output irq_pkg::cause_t   isr_cause
);
    import irq_pkg::*;

    logic   req;
    cause_t req_cause;
    logic   ack;

    irq_ctrl_if ctrl_bus ();    // redirect control from controller to sequencer

    irq_pending i_pending (
        .clk       (clk),
        .nrst      (nrst),
        .irq_n     (irq_n),
        .irq_mask  (irq_mask),
        .ack       (ack),
        .req       (req),
        .req_cause (req_cause)
    );

    pc_sequencer i_pc_seq (
        .clk           (clk),
        .nrst          (nrst),
        .ctrl          (ctrl_bus.seq),
        .save_pc       (save_pc),
        .fetch_en      (fetch_en),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (pc)
    );

    interrupt_controller i_ctrl (
        .clk           (clk),
        .nrst          (nrst),
        .req           (req),
        .req_cause     (req_cause),
        .ack           (ack),
        .pc            (pc),
        .instr         (instr),
        .fetch_en      (fetch_en),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .ctrl          (ctrl_bus.ctrl),
        .save_pc       (save_pc),
        .isr_active    (isr_active)
    );

    assign isr_stall = ctrl_bus.stall;
    assign isr_cause = ctrl_bus.cause;

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic nrst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset is let go on a falling edge, well away from the active edge
    initial begin
        nrst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/tb_irq_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_irq_top;
    import irq_pkg::*;

    localparam instr_t      NOP_INSTR     = 32'h00000013;
    localparam int          VECTOR_STRIDE = 16;         // bytes between two vectors
    localparam int          MAX_CYCLES    = 4000;       // the tests need a few hundred cycles
    localparam int          DRAIN_GUARD   = 64;
    localparam logic [15:0] LFSR_SEED     = 16'd16;

    logic     clk;
    logic     nrst;
    irq_vec_t irq_n;
    irq_vec_t irq_mask;
    instr_t   instr;
    logic     fetch_en;
    logic     branch_taken;
    pc_t      branch_target;
    pc_t      pc;
    pc_t      save_pc;
    logic     isr_stall;
    logic     isr_active;
    cause_t   isr_cause;

    int          errors;
    int          cycles = 0;
    logic [15:0] lfsr_state;
    pc_t         ret_expected;  // where the interrupt in service has to return to

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(8)) i_clk_gen (.clk(clk), .nrst(nrst));

    irq_top i_dut (
        .clk           (clk),
        .nrst          (nrst),
        .irq_n         (irq_n),
        .irq_mask      (irq_mask),
        .instr         (instr),
        .fetch_en      (fetch_en),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (pc),
        .save_pc       (save_pc),
        .isr_stall     (isr_stall),
        .isr_active    (isr_active),
        .isr_cause     (isr_cause)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[15:1]} ^ (out ? 16'hB400 : 16'h0000);
        return out;
    endfunction

    function automatic pc_t random_target();
        pc_t t;
        t = '0;
        for (int i = 0; i < 10; i++) begin
            t = {t[10:0], lfsr_bit()};
        end
        return t << 2;  // keep targets word aligned
    endfunction

    // fetch pc outside of interrupt entry and return
    function automatic pc_t model_next_pc(pc_t cur, logic en, logic br, pc_t tgt);
        if (br) begin
            return tgt;
        end
        if (en) begin
            return cur + pc_t'(4);
        end
        return cur;
    endfunction

    task automatic wait_stall_rise(input int limit, output logic rose, output pc_t pc_before);
        rose      = 1'b0;
        pc_before = pc;
        for (int i = 0; i < limit && !rose; i++) begin
            @(negedge clk);
            if (isr_stall) begin
                rose = 1'b1;
            end else begin
                pc_before = pc;     // last pc seen before the stall
            end
        end
    endtask

    // entered on the first falling edge that shows the stall
    task automatic run_drain(input logic gapped, input logic in_flight, input pc_t target,
                             input pc_t hold_pc);
        int enabled;
        int cycles_in_drain;
        enabled         = 0;
        cycles_in_drain = 0;
        while (isr_stall) begin
            if (cycles_in_drain == DRAIN_GUARD) begin
                $display("[%0t] isr_stall did not drop within %0d cycles", $time, DRAIN_GUARD);
                errors++;
                break;
            end
            check_equal("pc", hold_pc, pc);     // stall outranks branch_taken and fetch_en
            if (!gapped) begin
                fetch_en = 1'b1;
            end else if (cycles_in_drain == 0) begin
                fetch_en = 1'b0;                // every gapped drain opens with a dead cycle
            end else begin
                fetch_en = lfsr_bit();
            end
            branch_taken  = in_flight && (cycles_in_drain == 0);
            branch_target = target;
            if (fetch_en) begin
                enabled++;
            end
            cycles_in_drain++;
            @(negedge clk);
        end
        fetch_en     = 1'b1;
        branch_taken = 1'b0;
        check_equal("enabled drain cycles", DRAIN_CYCLES, enabled);
    endtask

    task automatic enter_isr(input cause_t cause, input logic gapped, input logic in_flight,
                             input pc_t target, output pc_t ret_pc);
        logic rose;
        pc_t  pc_before;
        wait_stall_rise(40, rose, pc_before);
        ret_pc = in_flight ? target : pc_before;
        if (!rose) begin
            $display("[%0t] isr_stall never rose for cause %0d", $time, cause);
            errors++;
        end else begin
            check_equal("save_pc", pc_before, save_pc);
            irq_n = '1;     // edges are long captured at this point
            // the accepting cycle still fetches before the stall holds the pc
            run_drain(gapped, in_flight, target, pc_before + pc_t'(4));
            check_equal("pc", ISR_BASE + pc_t'(cause) * pc_t'(VECTOR_STRIDE), pc);
            check_equal("isr_cause", cause, isr_cause);
            check_equal("isr_active", 1, isr_active);
            check_equal("save_pc", ret_pc, save_pc);
        end
    endtask

    task automatic leave_isr(input pc_t ret_pc, input logic gapped);
        pc_t uret_pc;
        uret_pc  = pc;
        instr    = URET_INSTR;
        fetch_en = 1'b1;
        @(negedge clk);
        instr = NOP_INSTR;
        check_equal("isr_stall", 1, isr_stall);
        run_drain(gapped, 1'b0, '0, uret_pc + pc_t'(4));   // the uret fetch still advances
        check_equal("pc", ret_pc, pc);
        check_equal("isr_active", 0, isr_active);
    endtask

    task automatic test_reset_and_sequence();
        pc_t exp_pc;
        check_equal("pc", 0, pc);
        check_equal("isr_stall", 0, isr_stall);
        check_equal("isr_active", 0, isr_active);
        exp_pc = '0;
        for (int i = 0; i < 32; i++) begin
            check_equal("pc", exp_pc, pc);
            fetch_en      = (i < 8) ? 1'b1 : lfsr_bit();  // steady run first and gaps after
            branch_taken  = (i == 12) || (i == 24);
            branch_target = random_target();
            exp_pc        = model_next_pc(exp_pc, fetch_en, branch_taken, branch_target);
            @(negedge clk);
        end
        check_equal("pc", exp_pc, pc);
        fetch_en     = 1'b1;
        branch_taken = 1'b0;
    endtask

    task automatic test_entry();
        irq_mask = '1;
        irq_n[2] = 1'b0;
        enter_isr(2, 1'b0, 1'b0, '0, ret_expected);
    endtask

    task automatic test_return();
        leave_isr(ret_expected, 1'b0);
    endtask

    task automatic test_mask_and_priority();
        logic rose;
        pc_t  pc_before;
        irq_mask = 4'b1110;     // line 0 is masked off
        irq_n[0] = 1'b0;
        wait_stall_rise(20, rose, pc_before);
        if (rose) begin
            $display("[%0t] isr_stall rose for an edge on a masked line", $time);
            errors++;
        end
        irq_n    = '1;
        irq_mask = '1;
        irq_n[1] = 1'b0;        // both lines fall in the same cycle
        irq_n[3] = 1'b0;
        enter_isr(1, 1'b0, 1'b0, '0, ret_expected);
        leave_isr(ret_expected, 1'b0);
        enter_isr(3, 1'b0, 1'b0, '0, ret_expected);  // left pending by the same edge
        leave_isr(ret_expected, 1'b0);
    endtask

    task automatic test_backpressure_branch();
        pc_t target;
        target   = random_target();
        irq_n[0] = 1'b0;
        enter_isr(0, 1'b1, 1'b1, target, ret_expected);
        leave_isr(ret_expected, 1'b1);
    endtask

    initial begin
        irq_n         = '1;
        irq_mask      = '1;
        instr         = NOP_INSTR;
        fetch_en      = 1'b0;
        branch_taken  = 1'b0;
        branch_target = '0;
        errors        = 0;
        lfsr_state    = LFSR_SEED;
        @(posedge nrst);
        @(negedge clk);
        test_reset_and_sequence();
        test_entry();
        test_return();
        test_mask_and_priority();
        test_backpressure_branch();
        $display("run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
hw/irq_pkg.sv
hw/irq_ctrl_if.sv
hw/irq_pending.sv
hw/pc_sequencer.sv
hw/interrupt_controller.sv
hw/irq_top.sv
sim/tb_clock_gen.sv
sim/tb_irq_top.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_irq_top -f project.f -o sim_irq_top
./obj_dir/sim_irq_top > sim.log
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
